/* rtl/ex_defines.svh */
// widths and RV32I encodings for the execute stage, include wherever a width or code is needed
`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

`define XLEN        32
`define REG_ADDR_W  5
`define SEL_W       4

// opcodes
`define OP_R        7'b0110011
`define OP_I        7'b0010011
`define OP_L        7'b0000011
`define OP_S        7'b0100011
`define OP_B        7'b1100011
`define OP_LUI      7'b0110111
`define OP_AUIPC    7'b0010111
`define OP_JAL      7'b1101111
`define OP_JALR     7'b1100111

// funct3, R and I groups share one encoding
`define F3_ADD      3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SR       3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

// funct3, loads
`define F3_LB       3'b000
`define F3_LH       3'b001
`define F3_LW       3'b010
`define F3_LBU      3'b100
`define F3_LHU      3'b101

// funct3, stores
`define F3_SB       3'b000
`define F3_SH       3'b001
`define F3_SW       3'b010

// funct3, branches
`define F3_BEQ      3'b000
`define F3_BNE      3'b001
`define F3_BLT      3'b100
`define F3_BGE      3'b101
`define F3_BLTU     3'b110
`define F3_BGEU     3'b111

`endif

/* rtl/ex_pkg.sv */
// types shared by the execute stage, imported by the load/store unit
`default_nettype none

`include "ex_defines.svh"

package ex_pkg;

    // one memory word, seen as byte lanes or as halfwords
    typedef union packed {
        logic [`XLEN/8-1:0][7:0]   lane;
        logic [`XLEN/16-1:0][15:0] half;
    } mem_word_u;

endpackage

`default_nettype wire

/* rtl/ex_op_if.sv */
// classified instruction bus from the decoder to the ALU, LSU and writeback blocks
`default_nettype none
`timescale 1ns/100ps

`include "ex_defines.svh"

interface ex_op_if;

    logic [`XLEN-1:0]       pc;
    logic [`XLEN-1:0]       reg1;
    logic [`XLEN-1:0]       reg2;
    logic [`XLEN-1:0]       imm;
    logic [2:0]             funct3;
    // inst[30], selects sub and sra
    logic                   alt;

    // one-hot instruction class
    logic                   cls_alu_r;
    logic                   cls_alu_i;
    logic                   cls_load;
    logic                   cls_store;
    logic                   cls_branch;
    logic                   cls_jal;
    logic                   cls_jalr;
    logic                   cls_lui;
    logic                   cls_auipc;

    logic [`REG_ADDR_W-1:0] rd;
    logic                   rd_we;

    modport src (
        output pc, reg1, reg2, imm, funct3, alt,
        output cls_alu_r, cls_alu_i, cls_load, cls_store, cls_branch,
        output cls_jal, cls_jalr, cls_lui, cls_auipc,
        output rd, rd_we
    );

    modport alu (
        input pc, reg1, reg2, imm, funct3, alt,
        input cls_alu_r, cls_alu_i, cls_branch, cls_jal, cls_jalr, cls_lui, cls_auipc
    );

    modport lsu (
        input reg1, reg2, imm, funct3, cls_load, cls_store
    );

    modport wb (
        input cls_load, rd, rd_we
    );

endinterface

`default_nettype wire

/* rtl/ex_decode.sv */
// input side of the execute stage, splits the instruction word into one-hot classes
`default_nettype none
`timescale 1ns/100ps

`include "ex_defines.svh"

module ex_decode (
    input  wire logic [`XLEN-1:0]       inst,
    input  wire logic [`XLEN-1:0]       pc,
    input  wire logic [`XLEN-1:0]       reg1,
    input  wire logic [`XLEN-1:0]       reg2,
    input  wire logic [`XLEN-1:0]       imm,
    input  wire logic [`REG_ADDR_W-1:0] reg_waddr,
    input  wire logic                   reg_we,
    ex_op_if.src                        op
);

    logic [6:0] opcode;
    logic [6:0] funct7;
    logic       funct7_ok;

    assign opcode    = inst[6:0];
    assign funct7    = inst[31:25];
    // only add/sub and srl/sra style funct7 values are legal
    assign funct7_ok = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);

    always_comb begin
        op.cls_alu_r  = 1'b0;
        op.cls_alu_i  = 1'b0;
        op.cls_load   = 1'b0;
        op.cls_store  = 1'b0;
        op.cls_branch = 1'b0;
        op.cls_jal    = 1'b0;
        op.cls_jalr   = 1'b0;
        op.cls_lui    = 1'b0;
        op.cls_auipc  = 1'b0;
        case (opcode)
            `OP_R:     op.cls_alu_r  = funct7_ok;
            `OP_I:     op.cls_alu_i  = 1'b1;
            `OP_L:     op.cls_load   = 1'b1;
            `OP_S:     op.cls_store  = 1'b1;
            `OP_B:     op.cls_branch = 1'b1;
            `OP_JAL:   op.cls_jal    = 1'b1;
            `OP_JALR:  op.cls_jalr   = 1'b1;
            `OP_LUI:   op.cls_lui    = 1'b1;
            `OP_AUIPC: op.cls_auipc  = 1'b1;
            // unknown opcode, no class
            default: ;
        endcase
    end

    assign op.funct3 = inst[14:12];
    assign op.alt    = inst[30];

    // operands pass through unchanged
    assign op.pc     = pc;
    assign op.reg1   = reg1;
    assign op.reg2   = reg2;
    assign op.imm    = imm;
    assign op.rd     = reg_waddr;
    assign op.rd_we  = reg_we;

endmodule

`default_nettype wire

/* rtl/ex_alu.sv */
// integer results, link value and branch/jump resolution of the execute stage
`default_nettype none
`timescale 1ns/100ps

`include "ex_defines.svh"

module ex_alu (
    ex_op_if.alu                 op,
    output logic [`XLEN-1:0]     alu_result,
    output logic                 taken,
    output logic [`XLEN-1:0]     target
);

    localparam int SHAMT_W = $clog2(`XLEN);

    logic [`XLEN-1:0]    opnd_b;
    logic [SHAMT_W-1:0]  shamt;
    logic [`XLEN-1:0]    sra_val;
    logic [`XLEN-1:0]    int_result;
    logic [`XLEN-1:0]    link;
    logic                is_jump;
    logic                br_cond;

    // R takes reg2, I takes the immediate
    assign opnd_b  = op.cls_alu_r ? op.reg2 : op.imm;
    assign shamt   = opnd_b[SHAMT_W-1:0];
    assign sra_val = $signed(op.reg1) >>> shamt;
    assign link    = op.pc + `XLEN'(4);
    assign is_jump = op.cls_jal | op.cls_jalr;

    always_comb begin
        case (op.funct3)
            `F3_ADD: begin
                // alt only means sub for R words, for addi it is an imm bit
                if (op.cls_alu_r && op.alt) begin
                    int_result = op.reg1 - opnd_b;
                end else begin
                    int_result = op.reg1 + opnd_b;
                end
            end
            `F3_SLL:  int_result = op.reg1 << shamt;
            `F3_SLT:  int_result = {{(`XLEN-1){1'b0}}, $signed(op.reg1) < $signed(opnd_b)};
            `F3_SLTU: int_result = {{(`XLEN-1){1'b0}}, op.reg1 < opnd_b};
            `F3_XOR:  int_result = op.reg1 ^ opnd_b;
            `F3_SR: begin
                if (op.alt) begin
                    int_result = sra_val;
                end else begin
                    int_result = op.reg1 >> shamt;
                end
            end
            `F3_OR:   int_result = op.reg1 | opnd_b;
            `F3_AND:  int_result = op.reg1 & opnd_b;
            default:  int_result = '0;
        endcase
    end

    always_comb begin
        if (op.cls_alu_r || op.cls_alu_i) begin
            alu_result = int_result;
        end else if (op.cls_lui) begin
            alu_result = op.imm;
        end else if (op.cls_auipc) begin
            alu_result = op.pc + op.imm;
        end else if (is_jump) begin
            alu_result = link;
        end else begin
            alu_result = '0;
        end
    end

    always_comb begin
        case (op.funct3)
            `F3_BEQ:  br_cond = op.reg1 == op.reg2;
            `F3_BNE:  br_cond = op.reg1 != op.reg2;
            `F3_BLT:  br_cond = $signed(op.reg1) < $signed(op.reg2);
            `F3_BGE:  br_cond = $signed(op.reg1) >= $signed(op.reg2);
            `F3_BLTU: br_cond = op.reg1 < op.reg2;
            `F3_BGEU: br_cond = op.reg1 >= op.reg2;
            default:  br_cond = 1'b0;
        endcase
    end

    assign taken = is_jump | (op.cls_branch & br_cond);

    always_comb begin
        if (!taken) begin
            target = '0;
        end else if (op.cls_jalr) begin
            // jalr drops bit 0
            target = (op.reg1 + op.imm) & ~`XLEN'(1);
        end else begin
            target = op.pc + op.imm;
        end
    end

endmodule

`default_nettype wire

/* rtl/ex_lsu.sv */
// load/store unit, drives the same-cycle memory request and extracts load data
`default_nettype none
`timescale 1ns/100ps

`include "ex_defines.svh"

module ex_lsu
    import ex_pkg::*;
(
    ex_op_if.lsu                 op,
    input  wire logic [`XLEN-1:0] ram_rdata,
    output logic                 ram_req,
    output logic                 ram_we,
    output logic [`SEL_W-1:0]    ram_sel,
    output logic [`XLEN-1:0]     ram_addr,
    output logic [`XLEN-1:0]     ram_wdata,
    output logic [`XLEN-1:0]     load_result
);

    localparam int LANE_W = $clog2(`SEL_W);

    localparam logic [`SEL_W-1:0] SEL_BYTE = `SEL_W'(1);
    localparam logic [`SEL_W-1:0] SEL_HALF = `SEL_W'(3);
    localparam logic [`SEL_W-1:0] SEL_WORD = '1;

    logic [`XLEN-1:0]  addr;
    logic [LANE_W-1:0] lane;
    mem_word_u         wr_word;
    mem_word_u         rd_word;
    logic [7:0]        ld_byte;
    logic [15:0]       ld_half;
    logic              half_ok;

    assign addr    = op.reg1 + op.imm;
    assign lane    = addr[LANE_W-1:0];
    // halfwords must sit on an even lane
    assign half_ok = ~addr[0];

    always_comb begin
        ram_req   = 1'b0;
        ram_we    = 1'b0;
        ram_sel   = '0;
        ram_addr  = '0;
        ram_wdata = '0;
        wr_word   = '0;
        if (op.cls_store) begin
            ram_req  = 1'b1;
            ram_we   = 1'b1;
            ram_addr = addr;
            case (op.funct3)
                `F3_SB: begin
                    wr_word.lane = {(`XLEN/8){op.reg2[7:0]}};
                    ram_sel      = SEL_BYTE << lane;
                end
                `F3_SH: begin
                    wr_word.half = {(`XLEN/16){op.reg2[15:0]}};
                    ram_sel      = half_ok ? (SEL_HALF << lane) : '0;
                end
                `F3_SW: begin
                    wr_word = op.reg2;
                    ram_sel = SEL_WORD;
                end
                default: begin
                    // not a store width, request withdrawn
                    ram_req  = 1'b0;
                    ram_we   = 1'b0;
                    ram_addr = '0;
                end
            endcase
            ram_wdata = wr_word;
        end else if (op.cls_load) begin
            ram_req  = 1'b1;
            ram_addr = addr;
            case (op.funct3)
                `F3_LB, `F3_LH, `F3_LW, `F3_LBU, `F3_LHU: ;
                default: begin
                    ram_req  = 1'b0;
                    ram_addr = '0;
                end
            endcase
        end
    end

    assign rd_word = ram_rdata;
    assign ld_byte = rd_word.lane[lane];
    assign ld_half = rd_word.half[lane[LANE_W-1]];

    always_comb begin
        load_result = '0;
        if (op.cls_load) begin
            case (op.funct3)
                `F3_LB:  load_result = {{(`XLEN-8){ld_byte[7]}}, ld_byte};
                `F3_LBU: load_result = {{(`XLEN-8){1'b0}}, ld_byte};
                `F3_LH: begin
                    if (half_ok) begin
                        load_result = {{(`XLEN-16){ld_half[15]}}, ld_half};
                    end
                end
                `F3_LHU: begin
                    if (half_ok) begin
                        load_result = {{(`XLEN-16){1'b0}}, ld_half};
                    end
                end
                `F3_LW:  load_result = rd_word;
                default: load_result = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/ex_writeback.sv */
// output register of the execute stage, forms the execute/memory boundary
`default_nettype none
`timescale 1ns/100ps

`include "ex_defines.svh"

module ex_writeback (
    input  wire logic                   clk,
    input  wire logic                   arst_n,
    ex_op_if.wb                         op,
    input  wire logic [`XLEN-1:0]       alu_result,
    input  wire logic [`XLEN-1:0]       load_result,
    input  wire logic                   taken,
    input  wire logic [`XLEN-1:0]       target,
    output logic                        rd_we,
    output logic [`REG_ADDR_W-1:0]      rd_waddr,
    output logic [`XLEN-1:0]            rd_wdata,
    output logic                        jump_flag,
    output logic [`XLEN-1:0]            jump_addr
);

    logic [`XLEN-1:0] wb_data;

    // loads return memory data, everything else the ALU value
    assign wb_data = op.cls_load ? load_result : alu_result;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_we     <= 1'b0;
            rd_waddr  <= '0;
            rd_wdata  <= '0;
            jump_flag <= 1'b0;
            jump_addr <= '0;
        end else begin
            rd_we     <= op.rd_we;
            rd_waddr  <= op.rd;
            rd_wdata  <= wb_data;
            // target is already zero when not taken
            jump_flag <= taken;
            jump_addr <= target;
        end
    end

endmodule

`default_nettype wire

/* rtl/ex_stage.sv */
// execute stage top, decoded instruction in, memory request out, registered result one cycle later
`default_nettype none
`timescale 1ns/100ps

`include "ex_defines.svh"

module ex_stage (
    input  wire logic                   clk,
    input  wire logic                   arst_n,
    input  wire logic [`XLEN-1:0]       pc,
    input  wire logic [`XLEN-1:0]       inst,
    input  wire logic [`XLEN-1:0]       reg1,
    input  wire logic [`XLEN-1:0]       reg2,
    input  wire logic [`XLEN-1:0]       imm,
    input  wire logic [`REG_ADDR_W-1:0] reg_waddr,
    input  wire logic                   reg_we,
    input  wire logic [`XLEN-1:0]       ram_rdata,
    output logic                        ram_req,
    output logic                        ram_we,
    output logic [`SEL_W-1:0]           ram_sel,
    output logic [`XLEN-1:0]            ram_addr,
    output logic [`XLEN-1:0]            ram_wdata,
    output logic                        rd_we,
    output logic [`REG_ADDR_W-1:0]      rd_waddr,
    output logic [`XLEN-1:0]            rd_wdata,
    output logic                        jump_flag,
    output logic [`XLEN-1:0]            jump_addr
);

    ex_op_if op_bus ();

    logic [`XLEN-1:0] alu_result;
    logic [`XLEN-1:0] load_result;
    logic             taken;
    logic [`XLEN-1:0] target;

    ex_decode decode_i (
        .inst      (inst),
        .pc        (pc),
        .reg1      (reg1),
        .reg2      (reg2),
        .imm       (imm),
        .reg_waddr (reg_waddr),
        .reg_we    (reg_we),
        .op        (op_bus.src)
    );

    ex_alu alu_i (
        .op         (op_bus.alu),
        .alu_result (alu_result),
        .taken      (taken),
        .target     (target)
    );

    // memory request leaves combinationally
    ex_lsu lsu_i (
        .op          (op_bus.lsu),
        .ram_rdata   (ram_rdata),
        .ram_req     (ram_req),
        .ram_we      (ram_we),
        .ram_sel     (ram_sel),
        .ram_addr    (ram_addr),
        .ram_wdata   (ram_wdata),
        .load_result (load_result)
    );

    ex_writeback writeback_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .op          (op_bus.wb),
        .alu_result  (alu_result),
        .load_result (load_result),
        .taken       (taken),
        .target      (target),
        .rd_we       (rd_we),
        .rd_waddr    (rd_waddr),
        .rd_wdata    (rd_wdata),
        .jump_flag   (jump_flag),
        .jump_addr   (jump_addr)
    );

endmodule

`default_nettype wire

/* bench/ex_stage_asserts.sv */
// concurrent checks on the execute stage top, attached to ex_stage by bind from the testbench
`default_nettype none
`timescale 1ns/100ps

`include "ex_defines.svh"

module ex_stage_asserts (
    input wire logic              clk,
    input wire logic              arst_n,
    input wire logic              ram_req,
    input wire logic              ram_we,
    input wire logic [`SEL_W-1:0] ram_sel,
    input wire logic              rd_we,
    input wire logic              jump_flag
);

    // failed assertions so far
    int fail_count = 0;

    // a write is always part of a request
    we_needs_req: assert property (@(posedge clk) ram_we |-> ram_req)
        else begin
            fail_count++;
            $error("ram_we high without ram_req");
        end

    // lanes only matter for writes
    sel_only_on_write: assert property (@(posedge clk) !ram_we |-> (ram_sel == '0))
        else begin
            fail_count++;
            $error("ram_sel nonzero while ram_we low");
        end

    // in reset and at the first edge after it nothing is registered yet
    quiet_after_reset: assert property (
        @(posedge clk) (!arst_n || $rose(arst_n)) |-> (!rd_we && !jump_flag))
        else begin
            fail_count++;
            $error("rd_we or jump_flag high around reset");
        end

endmodule

`default_nettype wire

/* bench/ex_stage_tb.sv */
// self-checking testbench for the execute stage, built and run through flist.f and the Makefile
`default_nettype none
`timescale 1ns/100ps

`include "ex_defines.svh"

module ex_stage_tb;

    localparam int          CLK_PERIOD = 100;
    localparam logic [31:0] PC_BASE    = 32'h0000_0100;
    localparam logic [31:0] BASE       = 32'h0000_1000;
    localparam logic [31:0] ST_DATA    = 32'ha1b2_c3d4;
    localparam logic [31:0] LD_WORD    = 32'h80f1_7f2e;
    localparam logic [31:0] BR_OFF     = 32'h0000_0020;
    localparam logic [31:0] NEG1       = 32'hffff_ffff;
    localparam logic [31:0] NEG2       = 32'hffff_fffe;

    typedef struct {
        string       name;
        logic [31:0] inst;
        logic [31:0] reg1;
        logic [31:0] reg2;
        logic [31:0] imm;
        logic [31:0] rdata;
        logic        req;
        logic        we;
        logic [3:0]  sel;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        rwe;
        logic [31:0] res;
        logic        jf;
        logic [31:0] jaddr;
    } vec_t;

    logic                   clk;
    logic                   arst_n;
    logic [`XLEN-1:0]       pc;
    logic [`XLEN-1:0]       inst;
    logic [`XLEN-1:0]       reg1;
    logic [`XLEN-1:0]       reg2;
    logic [`XLEN-1:0]       imm;
    logic [`REG_ADDR_W-1:0] reg_waddr;
    logic                   reg_we;
    logic [`XLEN-1:0]       ram_rdata;
    logic                   ram_req;
    logic                   ram_we;
    logic [`SEL_W-1:0]      ram_sel;
    logic [`XLEN-1:0]       ram_addr;
    logic [`XLEN-1:0]       ram_wdata;
    logic                   rd_we;
    logic [`REG_ADDR_W-1:0] rd_waddr;
    logic [`XLEN-1:0]       rd_wdata;
    logic                   jump_flag;
    logic [`XLEN-1:0]       jump_addr;

    vec_t vecs[$];
    logic built = 1'b0;
    int   n_checks = 0;
    int   n_errors = 0;

    ex_stage ex_stage_i (.*);

    bind ex_stage ex_stage_asserts asserts_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .ram_req   (ram_req),
        .ram_we    (ram_we),
        .ram_sel   (ram_sel),
        .rd_we     (rd_we),
        .jump_flag (jump_flag)
    );

    // only the fields the stage looks at, rd and rs fields stay zero
    function automatic logic [31:0] encode(logic [6:0] f7, logic [2:0] f3, logic [6:0] opc);
        return {f7, 10'd0, f3, 5'd0, opc};
    endfunction

    // stores and branches never write a register
    function automatic vec_t blank(string name, logic [31:0] iw, logic [31:0] r1,
                                   logic [31:0] r2, logic [31:0] iv);
        vec_t v;
        v.name  = name;
        v.inst  = iw;
        v.reg1  = r1;
        v.reg2  = r2;
        v.imm   = iv;
        v.rdata = LD_WORD;
        v.req   = 1'b0;
        v.we    = 1'b0;
        v.sel   = 4'h0;
        v.addr  = 32'h0;
        v.wdata = 32'h0;
        v.rwe   = (iw[6:0] != `OP_S) && (iw[6:0] != `OP_B);
        v.res   = 32'h0;
        v.jf    = 1'b0;
        v.jaddr = 32'h0;
        return v;
    endfunction

    // b feeds both reg2 and imm, R words use one and I words the other
    task automatic calc_entry(string name, logic [31:0] iw, logic [31:0] r1,
                              logic [31:0] b, logic [31:0] res);
        vec_t v;
        v = blank(name, iw, r1, b, b);
        v.res = res;
        vecs.push_back(v);
    endtask

    task automatic jump_entry(string name, logic [31:0] iw, logic [31:0] r1,
                              logic [31:0] iv, logic [31:0] ja);
        vec_t v;
        v = blank(name, iw, r1, 32'h0, iv);
        // link value
        v.res   = PC_BASE + 32'd4;
        v.jf    = 1'b1;
        v.jaddr = ja;
        vecs.push_back(v);
    endtask

    task automatic branch_entry(string name, logic [2:0] f3, logic [31:0] r1,
                                logic [31:0] r2, logic tk);
        vec_t v;
        v = blank(name, encode(7'h00, f3, `OP_B), r1, r2, BR_OFF);
        v.jf    = tk;
        v.jaddr = tk ? PC_BASE + BR_OFF : 32'h0;
        vecs.push_back(v);
    endtask

    task automatic mem_entry(string name, logic [31:0] iw, logic [31:0] off,
                             logic [3:0] sel, logic [31:0] wdata, logic [31:0] res);
        vec_t v;
        v = blank(name, iw, BASE, ST_DATA, off);
        v.req   = 1'b1;
        v.we    = (iw[6:0] == `OP_S);
        v.sel   = sel;
        v.addr  = BASE + off;
        v.wdata = wdata;
        v.res   = res;
        vecs.push_back(v);
    endtask

    task automatic compare(string name, string what, logic [31:0] exp, logic [31:0] act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("mismatch %s %s: expected %h, actual %h", name, what, exp, act);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        wait (built);
        #((vecs.size() + 10) * CLK_PERIOD);
        $display("watchdog: run timed out after %0d cycles", vecs.size() + 10);
        $display("test failed");
        $finish;
    end

    initial begin
        vec_t                   v;
        logic [`REG_ADDR_W-1:0] waddr;
        int                     n_assert_fails;
        arst_n    = 1'b0;
        pc        = PC_BASE;
        inst      = 32'h0;
        reg1      = 32'h0;
        reg2      = 32'h0;
        imm       = 32'h0;
        reg_waddr = '0;
        reg_we    = 1'b0;
        ram_rdata = 32'h0;

        calc_entry("sub", encode(7'h20, `F3_ADD, `OP_R), 32'd10, 32'd3, 32'd7);
        calc_entry("sra", encode(7'h20, `F3_SR, `OP_R), 32'hffffff00, 32'h4, 32'hfffffff0);
        calc_entry("slt", encode(7'h00, `F3_SLT, `OP_R), NEG1, 32'h1, 32'h1);
        calc_entry("sltu", encode(7'h00, `F3_SLTU, `OP_R), NEG1, 32'h1, 32'h0);
        calc_entry("srai", encode(7'h20, `F3_SR, `OP_I), 32'h80000000, 32'h404, 32'hf8000000);
        calc_entry("xori", encode(7'h00, `F3_XOR, `OP_I), 32'h0f0f0f0f, NEG1, 32'hf0f0f0f0);
        calc_entry("bad_f7", encode(7'h01, `F3_ADD, `OP_R), 32'h5, 32'h6, 32'h0);
        calc_entry("lui", encode(7'h00, 3'h0, `OP_LUI), 32'h0, 32'h12345000, 32'h12345000);
        calc_entry("auipc", encode(7'h00, 3'h0, `OP_AUIPC), 32'h0, 32'h2000, 32'h2100);
        // stores, replicated data and lane select
        mem_entry("sb0", encode(7'h00, `F3_SB, `OP_S), 32'h0, 4'b0001, 32'hd4d4d4d4, 32'h0);
        mem_entry("sb1", encode(7'h00, `F3_SB, `OP_S), 32'h1, 4'b0010, 32'hd4d4d4d4, 32'h0);
        mem_entry("sb2", encode(7'h00, `F3_SB, `OP_S), 32'h2, 4'b0100, 32'hd4d4d4d4, 32'h0);
        mem_entry("sb3", encode(7'h00, `F3_SB, `OP_S), 32'h3, 4'b1000, 32'hd4d4d4d4, 32'h0);
        mem_entry("sh0", encode(7'h00, `F3_SH, `OP_S), 32'h0, 4'b0011, 32'hc3d4c3d4, 32'h0);
        mem_entry("sh2", encode(7'h00, `F3_SH, `OP_S), 32'h2, 4'b1100, 32'hc3d4c3d4, 32'h0);
        mem_entry("sh_odd", encode(7'h00, `F3_SH, `OP_S), 32'h1, 4'b0000, 32'hc3d4c3d4, 32'h0);
        mem_entry("sw", encode(7'h00, `F3_SW, `OP_S), 32'h0, 4'b1111, ST_DATA, 32'h0);
        // loads from 80 f1 7f 2e
        mem_entry("lb0", encode(7'h00, `F3_LB, `OP_L), 32'h0, 4'h0, 32'h0, 32'h0000002e);
        mem_entry("lb1", encode(7'h00, `F3_LB, `OP_L), 32'h1, 4'h0, 32'h0, 32'h0000007f);
        mem_entry("lb2", encode(7'h00, `F3_LB, `OP_L), 32'h2, 4'h0, 32'h0, 32'hfffffff1);
        mem_entry("lb3", encode(7'h00, `F3_LB, `OP_L), 32'h3, 4'h0, 32'h0, 32'hffffff80);
        mem_entry("lbu0", encode(7'h00, `F3_LBU, `OP_L), 32'h0, 4'h0, 32'h0, 32'h0000002e);
        mem_entry("lbu1", encode(7'h00, `F3_LBU, `OP_L), 32'h1, 4'h0, 32'h0, 32'h0000007f);
        mem_entry("lbu2", encode(7'h00, `F3_LBU, `OP_L), 32'h2, 4'h0, 32'h0, 32'h000000f1);
        mem_entry("lbu3", encode(7'h00, `F3_LBU, `OP_L), 32'h3, 4'h0, 32'h0, 32'h00000080);
        mem_entry("lh0", encode(7'h00, `F3_LH, `OP_L), 32'h0, 4'h0, 32'h0, 32'h00007f2e);
        mem_entry("lh2", encode(7'h00, `F3_LH, `OP_L), 32'h2, 4'h0, 32'h0, 32'hffff80f1);
        mem_entry("lhu0", encode(7'h00, `F3_LHU, `OP_L), 32'h0, 4'h0, 32'h0, 32'h00007f2e);
        mem_entry("lhu2", encode(7'h00, `F3_LHU, `OP_L), 32'h2, 4'h0, 32'h0, 32'h000080f1);
        mem_entry("lw", encode(7'h00, `F3_LW, `OP_L), 32'h0, 4'h0, 32'h0, LD_WORD);
        branch_entry("beq_t", `F3_BEQ, 32'h5, 32'h5, 1'b1);
        branch_entry("beq_n", `F3_BEQ, 32'h5, 32'h6, 1'b0);
        branch_entry("bne_t", `F3_BNE, 32'h5, 32'h6, 1'b1);
        branch_entry("bne_n", `F3_BNE, 32'h5, 32'h5, 1'b0);
        branch_entry("blt_t", `F3_BLT, NEG2, 32'h1, 1'b1);
        branch_entry("blt_n", `F3_BLT, 32'h1, NEG2, 1'b0);
        branch_entry("bge_t", `F3_BGE, 32'h1, NEG2, 1'b1);
        branch_entry("bge_n", `F3_BGE, NEG2, 32'h1, 1'b0);
        branch_entry("bltu_t", `F3_BLTU, 32'h1, NEG2, 1'b1);
        branch_entry("bltu_n", `F3_BLTU, NEG2, 32'h1, 1'b0);
        branch_entry("bgeu_t", `F3_BGEU, NEG2, 32'h1, 1'b1);
        branch_entry("bgeu_n", `F3_BGEU, 32'h1, NEG2, 1'b0);
        jump_entry("jalr", encode(7'h00, 3'h0, `OP_JALR), 32'h2001, 32'h10, 32'h2010);
        // jal last, so the mid-run reset finds both flags high
        jump_entry("jal", encode(7'h00, 3'h0, `OP_JAL), 32'h0, 32'h40, 32'h140);
        built = 1'b1;

        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        foreach (vecs[i]) begin
            v         = vecs[i];
            waddr     = `REG_ADDR_W'(i + 1);
            inst      = v.inst;
            reg1      = v.reg1;
            reg2      = v.reg2;
            imm       = v.imm;
            reg_waddr = waddr;
            reg_we    = v.rwe;
            ram_rdata = v.rdata;
            // memory side, just before the rising edge
            #(CLK_PERIOD / 2 - CLK_PERIOD / 10);
            compare(v.name, "ram_req", 32'(v.req), 32'(ram_req));
            compare(v.name, "ram_we", 32'(v.we), 32'(ram_we));
            compare(v.name, "ram_sel", 32'(v.sel), 32'(ram_sel));
            compare(v.name, "ram_addr", v.addr, ram_addr);
            compare(v.name, "ram_wdata", v.wdata, ram_wdata);
            @(posedge clk);
            #1;
            compare(v.name, "rd_we", 32'(v.rwe), 32'(rd_we));
            compare(v.name, "rd_waddr", 32'(waddr), 32'(rd_waddr));
            if (v.rwe) begin
                compare(v.name, "rd_wdata", v.res, rd_wdata);
            end
            compare(v.name, "jump_flag", 32'(v.jf), 32'(jump_flag));
            compare(v.name, "jump_addr", v.jaddr, jump_addr);
            @(negedge clk);
        end

        inst   = 32'h0;
        reg_we = 1'b0;
        arst_n = 1'b0;
        #1;
        compare("mid_reset", "rd_we", 32'h0, 32'(rd_we));
        compare("mid_reset", "jump_flag", 32'h0, 32'(jump_flag));
        compare("mid_reset", "jump_addr", 32'h0, jump_addr);
        compare("mid_reset", "rd_wdata", 32'h0, rd_wdata);
        compare("mid_reset", "ram_req", 32'h0, 32'(ram_req));
        @(negedge clk);
        arst_n = 1'b1;

        n_assert_fails = ex_stage_i.asserts_i.fail_count;
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 n_checks, n_errors, n_assert_fails);
        if (n_errors == 0 && n_assert_fails == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+rtl
rtl/ex_pkg.sv
rtl/ex_op_if.sv
rtl/ex_decode.sv
rtl/ex_alu.sv
rtl/ex_lsu.sv
rtl/ex_writeback.sv
rtl/ex_stage.sv
bench/ex_stage_asserts.sv
bench/ex_stage_tb.sv

/* Makefile */
# Verilator build and run of the execute stage testbench
TOP := ex_stage_tb
LOG := sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f flist.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	! grep -q "test failed" $(LOG)
	grep -q "test passed" $(LOG)

lint:
	verilator --lint-only --timing --assert --timescale 1ns/100ps \
		-f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
